// ==== dv/dbg_testdata.txt ====
// Per test: word count, mode (1 = step), max ack delay, max ready gap,
// expected halt PC, expected run count, then the program words. Count 0 ends.
00000004 00000000 00000000 00000000 0000000c 00000003
3c010001 24210005 00221820 00000000
00000003 00000001 00000003 00000002 00000008 00000002
20080007 21090001 00000000
00000006 00000000 00000007 00000005 00000014 00000005
8c220004 ac230008 01094020 1109fffe 34a5ffff 00000000
00000001 00000001 00000005 00000003 00000000 00000000
00000000
00000005 00000001 00000002 00000001 00000010 00000004
11112222 33334444 80000001 00ff00ff 00000000
00000005 00000000 00000004 00000007 00000010 00000004
0badcafe 12345678 fedcba98 00000100 00000000
00000000

// ==== dbg_top.f ====
+incdir+hw
hw/dbg_types_pkg.sv
hw/dbg_wb_pkg.sv
hw/dbg_cmd_fsm.sv
hw/dbg_prog_loader.sv
hw/dbg_report_tx.sv
hw/dbg_top.sv
dv/dbg_top_props.sv
dv/dbg_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the debug unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f dbg_top.f --top-module dbg_tb \
  -o dbg_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/dbg_sim > sim.log 2>&1
cat sim.log

grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== dv/dbg_tb.sv ====
`timescale 1ns/1ps

`include "dbg_macros.svh"

module dbg_tb;

  import dbg_types_pkg::*;
  import dbg_wb_pkg::*;

  localparam int BYTE_GAP = 3;  // Idle cycles after each host byte.

  logic    clock;
  logic    reset;
  logic    rx_valid;
  byte_t   rx_data;
  logic    tx_valid;
  byte_t   tx_data;
  logic    tx_ready;
  wb_m2s_t wb_req;
  wb_s2m_t wb_rsp;
  logic    cpu_run;
  pc_t     pc;
  word_t   fetch_instr;

  word_t       tdata [0:255];  // Test file image.
  word_t       imem [0:2047];  // Instruction memory model.
  word_t       prog [$];
  addr_t       wr_adr [$];     // Writes seen on the bus.
  word_t       wr_dat [$];
  byte_t       tx_bytes [$];
  int          test_idx;
  int          ack_max;
  int          gap_max;
  int          run_count;
  logic [31:0] lfsr_state;
  int          watchdog_ns;
  logic        watchdog_armed;

  dbg_top u_dbg_top (
    .i_clock(clock), .i_reset(reset), .i_rx_valid(rx_valid), .i_rx_data(rx_data),
    .o_tx_valid(tx_valid), .o_tx_data(tx_data), .i_tx_ready(tx_ready),
    .o_wb(wb_req), .i_wb(wb_rsp), .o_cpu_run(cpu_run), .i_pc(pc),
    .i_fetch_instr(fetch_instr)
  );

  assign fetch_instr = imem[pc[12:2]];

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  ////////////////////////////////////////
  // Checks and helpers.
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Galois LFSR stepped once per bit taken.
  task automatic draw_random(input int nbits, output int value);
    value = 0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      value = (value << 1) | int'(lfsr_state[0]);
    end
  endtask

  task automatic send_byte(input byte_t value);
    @(posedge clock);
    #5;
    rx_valid = 1'b1;  // One-cycle pulse.
    rx_data  = value;
    @(posedge clock);
    #5;
    rx_valid = 1'b0;
    repeat (BYTE_GAP) @(posedge clock);
  endtask

  task automatic wait_for_state(input state_e target);
    while (u_dbg_top.u_cmd_fsm.state_q != target) @(negedge clock);
  endtask

  ////////////////////////////////////////
  // Memory and transmit sink models.
  ////////////////////////////////////////

  initial begin
    int delay_left;
    int gap_left;
    int seen_test;
    int r;
    logic armed;
    for (int a = 0; a < 2048; a++) imem[a] = 32'hA500_0000 | 32'(a);  // Nonzero fill.
    lfsr_state = 32'h99f19a21;
    wb_rsp     = '0;
    tx_ready   = 1'b0;
    armed      = 1'b0;
    delay_left = 0;
    gap_left   = 0;
    seen_test  = -1;
    forever begin
      @(posedge clock);
      #5;
      if (seen_test != test_idx) begin
        wr_adr.delete();
        wr_dat.delete();
        tx_bytes.delete();
        seen_test = test_idx;
      end
      if (wb_rsp.ack) begin
        wb_rsp.ack = 1'b0;  // Single-cycle ack.
      end else if (wb_req.cyc && wb_req.stb && wb_req.we) begin
        if (!armed) begin
          draw_random(4, r);
          delay_left = r % (ack_max + 1);
          armed      = 1'b1;
        end
        if (delay_left == 0) begin
          imem[wb_req.adr] = wb_req.dat;
          wr_adr.push_back(wb_req.adr);
          wr_dat.push_back(wb_req.dat);
          wb_rsp.ack = 1'b1;
          armed      = 1'b0;
        end else begin
          delay_left--;
        end
      end
      if (gap_left > 0) begin
        tx_ready = 1'b0;
        gap_left--;
      end else begin
        tx_ready = 1'b1;
        if (tx_valid) begin
          tx_bytes.push_back(tx_data);  // Taken at the next edge.
          draw_random(4, r);
          gap_left = r % (gap_max + 1);
        end
      end
    end
  end

  // CPU model steps PC by 4 on each run edge.
  initial begin
    logic advance;
    int   seen_test;
    pc        = '0;
    run_count = 0;
    seen_test = -1;
    forever begin
      @(negedge clock);
      advance = cpu_run;
      if (advance) run_count++;
      @(posedge clock);
      #5;
      if (seen_test != test_idx) begin
        pc        = '0;
        run_count = 0;
        seen_test = test_idx;
      end else if (advance) begin
        pc = pc + 16'd4;
      end
    end
  end

  initial begin
    wait (watchdog_armed);
    #(watchdog_ns);
    $display("Timeout: the tests did not finish in the expected time");
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////
  // Test sequence.
  ////////////////////////////////////////

  initial begin
    int p;
    int n;
    int steps;
    int prev_runs;
    int cycles;
    rx_valid = 1'b0;
    rx_data  = '0;
    reset    = 1'b0;
    test_idx = 0;
    ack_max  = 0;
    gap_max  = 0;
    watchdog_armed = 1'b0;
    for (int i = 0; i < 256; i++) tdata[i] = '0;
    $readmemh("dv/dbg_testdata.txt", tdata);
    p      = 0;
    cycles = 100;
    while (tdata[p] != 0) begin
      n = int'(tdata[p]);
      cycles += (2 + 5 * n) * (BYTE_GAP + 2) + n * (tdata[p+2] + 2) + 8 * (tdata[p+3] + 2) + 50;
      p += 6 + n;
    end
    watchdog_ns    = (cycles + 10) * 100 * 2;
    watchdog_armed = 1'b1;
    repeat (10) @(posedge clock);
    #5;
    reset = 1'b1;
    p = 0;
    while (tdata[p] != 0) begin
      n       = int'(tdata[p]);
      ack_max = int'(tdata[p+2]);
      gap_max = int'(tdata[p+3]);
      prog.delete();
      for (int i = 0; i < n; i++) prog.push_back(tdata[p+6+i]);
      test_idx++;
      send_byte(`DBG_CMD_LOAD);
      foreach (prog[i]) begin
        for (int b = 3; b >= 0; b--) send_byte(prog[i][8*b +: 8]);  // MSB first.
      end
      wait_for_state(WAIT_START);
      check_value("wb_write_count", wr_adr.size(), n);
      foreach (wr_adr[i]) begin
        check_value("wb_adr", 32'(wr_adr[i]), i);
        check_value("wb_dat", wr_dat[i], prog[i]);
      end
      if (tdata[p+1] != 0) begin
        send_byte(`DBG_CMD_RUN_STEP);
        steps = 0;
        while (fetch_instr != `DBG_HALT_OPCODE) begin
          prev_runs = run_count;
          send_byte(`DBG_CMD_STEP);
          check_value("o_cpu_run_pulses", run_count, prev_runs + 1);
          steps++;
        end
        check_value("step_count", steps, tdata[p+5]);
      end else begin
        send_byte(`DBG_CMD_RUN);
      end
      while (tx_bytes.size() < `DBG_REPORT_BYTES) @(posedge clock);
      wait_for_state(IDLE);
      check_value("tx_byte_count", tx_bytes.size(), `DBG_REPORT_BYTES);
      check_value("report_pc", 32'({tx_bytes[0], tx_bytes[1]}), tdata[p+4]);
      check_value("report_pc_plus_4", 32'({tx_bytes[2], tx_bytes[3]}), tdata[p+4] + 4);
      check_value("report_count", {tx_bytes[4], tx_bytes[5], tx_bytes[6], tx_bytes[7]},
                  tdata[p+5]);
      check_value("run_cycles", run_count, tdata[p+5]);
      p += 6 + n;
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== dv/dbg_top_props.sv ====
`timescale 1ns/1ps

module dbg_top_props (
  input logic                  i_clock,
  input logic                  i_reset,
  input dbg_wb_pkg::wb_m2s_t   i_wb_req,
  input dbg_wb_pkg::wb_s2m_t   i_wb_rsp,
  input logic                  i_tx_valid,
  input logic                  i_tx_ready,
  input dbg_types_pkg::byte_t  i_tx_data,
  input logic                  i_cpu_run,
  input dbg_types_pkg::state_e i_state
);

  import dbg_types_pkg::*;

  ////////////////////////////////////////
  // Wishbone request.
  ////////////////////////////////////////

  assert property (@(posedge i_clock) disable iff (!i_reset)
    i_wb_req.cyc == i_wb_req.stb)
    else $error("wishbone cyc and stb differ");

  assert property (@(posedge i_clock) disable iff (!i_reset)
    (i_wb_req.cyc && !i_wb_rsp.ack) |=>
      (i_wb_req.cyc && i_wb_req.we && $stable(i_wb_req.adr) && $stable(i_wb_req.dat)))
    else $error("wishbone request changed before ack");

  // Stalled transmit byte.
  assert property (@(posedge i_clock) disable iff (!i_reset)
    (i_tx_valid && !i_tx_ready) |=> (i_tx_valid && $stable(i_tx_data)))
    else $error("tx byte changed while stalled");

  assert property (@(posedge i_clock) disable iff (!i_reset)
    (i_state == LOAD) |-> !i_cpu_run)
    else $error("cpu run high during load");

endmodule

bind dbg_top dbg_top_props u_props (
  .i_clock(i_clock), .i_reset(i_reset), .i_wb_req(o_wb), .i_wb_rsp(i_wb),
  .i_tx_valid(o_tx_valid), .i_tx_ready(i_tx_ready), .i_tx_data(o_tx_data),
  .i_cpu_run(o_cpu_run), .i_state(u_cmd_fsm.state_q)
);

// ==== hw/dbg_top.sv ====
`timescale 1ns/1ps

module dbg_top (
  input  logic                 i_clock,
  input  logic                 i_reset,
  input  logic                 i_rx_valid,
  input  dbg_types_pkg::byte_t i_rx_data,
  output logic                 o_tx_valid,
  output dbg_types_pkg::byte_t o_tx_data,
  input  logic                 i_tx_ready,
  output dbg_wb_pkg::wb_m2s_t  o_wb,
  input  dbg_wb_pkg::wb_s2m_t  i_wb,
  output logic                 o_cpu_run,
  input  dbg_types_pkg::pc_t   i_pc,
  input  dbg_types_pkg::word_t i_fetch_instr
);

  logic load_en;
  logic load_done;
  logic run;
  logic report_start;
  logic report_done;

  dbg_cmd_fsm u_cmd_fsm (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_rx_valid     (i_rx_valid),
    .i_rx_data      (i_rx_data),
    .i_load_done    (load_done),
    .i_fetch_instr  (i_fetch_instr),
    .i_report_done  (report_done),
    .o_load_en      (load_en),
    .o_cpu_run      (run),
    .o_report_start (report_start)
  );

  dbg_prog_loader u_prog_loader (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_load_en   (load_en),
    .i_rx_valid  (i_rx_valid),
    .i_rx_data   (i_rx_data),
    .i_wb        (i_wb),
    .o_wb        (o_wb),
    .o_load_done (load_done)
  );

  dbg_report_tx u_report_tx (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_run          (run),
    .i_report_start (report_start),
    .i_pc           (i_pc),
    .i_tx_ready     (i_tx_ready),
    .o_tx_valid     (o_tx_valid),
    .o_tx_data      (o_tx_data),
    .o_report_done  (report_done)
  );

  assign o_cpu_run = run;

endmodule

// ==== hw/dbg_report_tx.sv ====
`timescale 1ns/1ps

`include "dbg_macros.svh"

module dbg_report_tx (
  input  logic                 i_clock,
  input  logic                 i_reset,
  input  logic                 i_run,
  input  logic                 i_report_start,
  input  dbg_types_pkg::pc_t   i_pc,
  input  logic                 i_tx_ready,
  output logic                 o_tx_valid,
  output dbg_types_pkg::byte_t o_tx_data,
  output logic                 o_report_done
);

  import dbg_types_pkg::*;

  localparam int unsigned REPORT_BITS = `DBG_REPORT_BYTES * 8;

  count_t                 run_cnt_q;
  logic [REPORT_BITS-1:0] report_sr_q;   // PC, PC+4, count.
  logic [2:0]             bytes_left_q;  // Bytes after the current one.
  logic                   tx_valid_q;
  logic                   done_q;
  pc_t                    pc_next;
  logic                   byte_taken;
  logic                   last_byte;

  assign pc_next    = i_pc + 16'd4;
  assign byte_taken = tx_valid_q && i_tx_ready;
  assign last_byte  = byte_taken && (bytes_left_q == 3'd0);

  ////////////////////////////////////////
  // Cycle counter and byte sequencing.
  ////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      run_cnt_q    <= '0;
      bytes_left_q <= '0;
      tx_valid_q   <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      done_q <= last_byte;
      if (i_report_start) begin
        tx_valid_q   <= 1'b1;
        bytes_left_q <= 3'(`DBG_REPORT_BYTES - 1);
      end else if (byte_taken) begin
        bytes_left_q <= bytes_left_q - 3'd1;
        if (last_byte) begin
          tx_valid_q <= 1'b0;
        end
      end
      if (last_byte) begin
        run_cnt_q <= '0;  // Next run counts from zero.
      end else if (i_run) begin
        run_cnt_q <= run_cnt_q + 32'd1;
      end
    end
  end

  // Snapshot, then shift out MSB first.
  always_ff @(posedge i_clock) begin
    if (i_report_start) begin
      report_sr_q <= {i_pc, pc_next, run_cnt_q};
    end else if (byte_taken) begin
      report_sr_q <= {report_sr_q[REPORT_BITS-9:0], 8'h00};
    end
  end

  assign o_tx_valid    = tx_valid_q;
  assign o_tx_data     = report_sr_q[REPORT_BITS-1 -: 8];
  assign o_report_done = done_q;

endmodule

// ==== hw/dbg_prog_loader.sv ====
`timescale 1ns/1ps

`include "dbg_macros.svh"

module dbg_prog_loader (
  input  logic                 i_clock,
  input  logic                 i_reset,
  input  logic                 i_load_en,
  input  logic                 i_rx_valid,
  input  dbg_types_pkg::byte_t i_rx_data,
  input  dbg_wb_pkg::wb_s2m_t  i_wb,
  output dbg_wb_pkg::wb_m2s_t  o_wb,
  output logic                 o_load_done
);

  import dbg_types_pkg::*;

  word_t      byte_sr_q;    // Earlier bytes of the current word.
  logic [1:0] byte_cnt_q;
  addr_t      adr_q;        // Next write address.
  logic       req_valid_q;  // Write pending on the bus.
  addr_t      req_adr_q;
  word_t      req_dat_q;
  logic       halt_seen_q;
  logic       load_done_q;
  logic       ack;
  logic       take_byte;
  logic       word_done;
  word_t      word_next;
  addr_t      adr_next;

  assign ack       = req_valid_q && i_wb.ack;
  assign take_byte = i_load_en && i_rx_valid && !halt_seen_q;  // Nothing after halt.
  assign word_done = take_byte && (byte_cnt_q == 2'd3);
  assign word_next = {byte_sr_q[23:0], i_rx_data};  // MSB first.
  assign adr_next  = ack ? adr_q + addr_t'(1) : adr_q;

  ////////////////////////////////////////
  // Counters and request control.
  ////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      byte_cnt_q  <= '0;
      adr_q       <= '0;
      req_valid_q <= 1'b0;
      halt_seen_q <= 1'b0;
      load_done_q <= 1'b0;
    end else begin
      load_done_q <= ack && halt_seen_q;
      if (word_done) begin
        req_valid_q <= 1'b1;
      end else if (ack) begin
        req_valid_q <= 1'b0;
      end
      if (!i_load_en) begin
        byte_cnt_q  <= '0;
        adr_q       <= '0;
        halt_seen_q <= 1'b0;
      end else begin
        adr_q <= adr_next;
        if (take_byte) begin
          byte_cnt_q <= byte_cnt_q + 2'd1;
        end
        if (word_done && (word_next == `DBG_HALT_OPCODE)) begin
          halt_seen_q <= 1'b1;
        end
      end
    end
  end

  // Word assembly and held request.
  always_ff @(posedge i_clock) begin
    if (take_byte) begin
      byte_sr_q <= word_next;
    end
    if (word_done) begin
      req_adr_q <= adr_next;  // Covers an ack in the same cycle.
      req_dat_q <= word_next;
    end
  end

  assign o_wb = '{
    cyc: req_valid_q,
    stb: req_valid_q,
    we:  req_valid_q,
    adr: req_adr_q,
    dat: req_dat_q
  };
  assign o_load_done = load_done_q;

endmodule

// ==== hw/dbg_cmd_fsm.sv ====
`timescale 1ns/1ps

`include "dbg_macros.svh"

module dbg_cmd_fsm (
  input  logic                 i_clock,
  input  logic                 i_reset,
  input  logic                 i_rx_valid,
  input  dbg_types_pkg::byte_t i_rx_data,
  input  logic                 i_load_done,
  input  dbg_types_pkg::word_t i_fetch_instr,
  input  logic                 i_report_done,
  output logic                 o_load_en,
  output logic                 o_cpu_run,
  output logic                 o_report_start
);

  import dbg_types_pkg::*;

  state_e state_q;
  state_e state_d;
  logic   step_mode_q;     // Set by bit 2 of the start byte.
  logic   report_start_q;
  logic   halted;
  logic   start_cmd;

  assign halted    = (i_fetch_instr == `DBG_HALT_OPCODE);
  assign start_cmd = i_rx_valid &&
                     ((i_rx_data == `DBG_CMD_RUN) || (i_rx_data == `DBG_CMD_RUN_STEP));

  ////////////////////////////////////////
  // Next state.
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (i_rx_valid && (i_rx_data == `DBG_CMD_LOAD)) begin
          state_d = LOAD;
        end
      end
      LOAD: begin
        if (i_load_done) begin
          state_d = WAIT_START;
        end
      end
      WAIT_START: begin
        if (start_cmd) begin
          state_d = i_rx_data[2] ? STEP_WAIT : RUN;  // Step mode waits for first step.
        end
      end
      RUN: begin
        if (halted) begin
          state_d = REPORT;
        end else if (step_mode_q) begin
          state_d = STEP_WAIT;  // One cycle per step.
        end
      end
      STEP_WAIT: begin
        // Halt is checked before another step is taken.
        if (halted) begin
          state_d = REPORT;
        end else if (i_rx_valid && (i_rx_data == `DBG_CMD_STEP)) begin
          state_d = RUN;
        end
      end
      REPORT: begin
        if (i_report_done) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // State and mode registers.
  ////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state_q        <= IDLE;
      step_mode_q    <= 1'b0;
      report_start_q <= 1'b0;
    end else begin
      state_q        <= state_d;
      report_start_q <= (state_d == REPORT) && (state_q != REPORT);  // Entry pulse.
      if ((state_q == WAIT_START) && start_cmd) begin
        step_mode_q <= i_rx_data[2];
      end
    end
  end

  assign o_load_en      = (state_q == LOAD);
  assign o_cpu_run      = (state_q == RUN) && !halted;  // Drops in the halt fetch cycle.
  assign o_report_start = report_start_q;

endmodule

// ==== hw/dbg_wb_pkg.sv ====
package dbg_wb_pkg;

  // Master to slave request of a classic single write.
  typedef struct packed {
    logic                 cyc;  // Bus cycle.
    logic                 stb;  // Strobe follows cyc.
    logic                 we;   // Write enable.
    dbg_types_pkg::addr_t adr;  // Word address.
    dbg_types_pkg::word_t dat;  // Write data.
  } wb_m2s_t;

  // Slave to master reply.
  typedef struct packed {
    logic ack;  // Write accepted.
  } wb_s2m_t;

endpackage

// ==== hw/dbg_types_pkg.sv ====
package dbg_types_pkg;

  ////////////////////////////////////////
  // Data widths of the MIPS debug path.
  ////////////////////////////////////////

  typedef logic [7:0]  byte_t;   // Serial byte.
  typedef logic [31:0] word_t;   // Instruction word.
  typedef logic [10:0] addr_t;   // Instruction memory word address.
  typedef logic [15:0] pc_t;     // Program counter.
  typedef logic [31:0] count_t;  // Run cycle count.

  ////////////////////////////////////////
  // Controller states.
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE       = 3'd0,  // Waiting for load command.
    LOAD       = 3'd1,  // Receiving program bytes.
    WAIT_START = 3'd2,  // Waiting for a start byte.
    RUN        = 3'd3,  // CPU enabled.
    STEP_WAIT  = 3'd4,  // Waiting for a step byte.
    REPORT     = 3'd5   // Sending the halt report.
  } state_e;

endpackage

// ==== hw/dbg_macros.svh ====
`ifndef DBG_MACROS_SVH
`define DBG_MACROS_SVH

////////////////////////////////////////
// Host command bytes.
////////////////////////////////////////

`define DBG_CMD_LOAD      8'h01  // Start of program load.
`define DBG_CMD_RUN       8'h03  // Continuous run.
`define DBG_CMD_RUN_STEP  8'h07  // Step mode has bit 2 set.
`define DBG_CMD_STEP      8'h08  // One instruction.

////////////////////////////////////////
// Program and report constants.
////////////////////////////////////////

`define DBG_HALT_OPCODE   32'h0000_0000  // All-zero halt word.
`define DBG_REPORT_BYTES  8              // PC, PC+4, cycle count.

`endif
